// ==== common/mips_isa_pkg.sv ====
package mips_isa_pkg;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_sltiu   = 6'h0b,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f,
    op_lb      = 6'h20,
    op_lw      = 6'h23,
    op_lbu     = 6'h24,
    op_sb      = 6'h28,
    op_sw      = 6'h2b
  } opcode_t;

  // SPECIAL function codes, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_sra  = 6'h03,
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_nor  = 6'h27,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_nor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_lui
  } alu_op_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_memory,
    st_writeback,
    st_halt
  } cpu_state_t;

endpackage

// ==== common/avalon_bus_pkg.sv ====
package avalon_bus_pkg;

  localparam int bus_width = 32;
  localparam int lane_count = 4;

  typedef logic [bus_width-1:0] bus_word_t;
  typedef logic [lane_count-1:0] byte_mask_t;

  // memory is big-endian, bus lane 0 holds the lowest address
  function automatic bus_word_t byte_swap(input bus_word_t word);
    bus_word_t swapped;
    for (int i = 0; i < lane_count; i++) begin
      swapped[8*i +: 8] = word[8*(lane_count-1-i) +: 8];
    end
    return swapped;
  endfunction

endpackage

// ==== common/cpu_ctrl_if.sv ====
`timescale 1ns/1ps

interface cpu_ctrl_if;
  import mips_isa_pkg::*;

  // sequencing
  logic ir_write;
  logic pc_write;
  logic pc_write_cond;
  logic branch_on_ne;
  logic [1:0] pc_source;

  // operand and result selection
  logic iord;
  logic alu_src_a;
  logic [1:0] alu_src_b;
  alu_op_t alu_op;
  logic [1:0] reg_dst;
  logic mem_to_reg;
  logic reg_write;
  logic alu_out_en;

  // bus access
  logic mem_read;
  logic mem_write;
  logic load_byte;
  logic load_signed;
  logic store_byte;

  // status back to the FSM
  opcode_t opcode;
  funct_t funct;
  logic zero;
  logic pc_is_zero;

  modport controller (
    output ir_write, pc_write, pc_write_cond, branch_on_ne, pc_source,
    output iord, alu_src_a, alu_src_b, alu_op, reg_dst, mem_to_reg, reg_write, alu_out_en,
    output mem_read, mem_write, load_byte, load_signed, store_byte,
    input  opcode, funct, zero, pc_is_zero
  );

  modport datapath (
    input  ir_write, pc_write, pc_write_cond, branch_on_ne, pc_source,
    input  iord, alu_src_a, alu_src_b, alu_op, reg_dst, mem_to_reg, reg_write, alu_out_en,
    input  mem_read, mem_write, load_byte, load_signed, store_byte,
    output opcode, funct, zero, pc_is_zero
  );

endinterface

// ==== datapath/mips_cpu_alu.sv ====
`timescale 1ns/1ps

module mips_cpu_alu (
  input  mips_isa_pkg::alu_op_t op,
  input  avalon_bus_pkg::bus_word_t a,
  input  avalon_bus_pkg::bus_word_t b,
  input  logic [4:0] shamt,
  output avalon_bus_pkg::bus_word_t result,
  output logic zero
);
  import mips_isa_pkg::*;
  import avalon_bus_pkg::*;

  logic less_signed;
  logic less_unsigned;

  assign less_signed = $signed(a) < $signed(b);
  assign less_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_nor:  result = ~(a | b);
      alu_slt:  result = {{(bus_width-1){1'b0}}, less_signed};
      alu_sltu: result = {{(bus_width-1){1'b0}}, less_unsigned};
      // shifts act on the rt operand
      alu_sll:  result = b << shamt;
      alu_srl:  result = b >> shamt;
      alu_sra:  result = $signed(b) >>> shamt;
      alu_lui:  result = {b[15:0], 16'h0000};
      default:  result = a + b;
    endcase
  end

  // beq/bne compare through sub
  assign zero = (result == '0);

endmodule

// ==== datapath/mips_cpu_register_file.sv ====
`timescale 1ns/1ps

module mips_cpu_register_file (
  input  logic clk,
  input  logic reset,
  input  logic write_enable,
  input  logic [4:0] read_reg_1,
  input  logic [4:0] read_reg_2,
  input  logic [4:0] write_reg,
  input  avalon_bus_pkg::bus_word_t write_data,
  output avalon_bus_pkg::bus_word_t read_data_1,
  output avalon_bus_pkg::bus_word_t read_data_2,
  output avalon_bus_pkg::bus_word_t read_data_v0
);
  import avalon_bus_pkg::*;

  bus_word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_reg != 5'd0)) begin
      regs[write_reg] <= write_data;
    end
  end

  assign read_data_1 = (read_reg_1 == 5'd0) ? '0 : regs[read_reg_1];
  assign read_data_2 = (read_reg_2 == 5'd0) ? '0 : regs[read_reg_2];
  // v0 for the result port
  assign read_data_v0 = regs[2];

endmodule

// ==== datapath/mips_cpu_mem_align.sv ====
`timescale 1ns/1ps

module mips_cpu_mem_align (
  input  logic [1:0] byte_offset,
  input  logic store_byte,
  input  logic load_byte,
  input  logic load_signed,
  input  avalon_bus_pkg::bus_word_t store_data,
  input  avalon_bus_pkg::bus_word_t load_word,
  output avalon_bus_pkg::bus_word_t writedata,
  output avalon_bus_pkg::bus_word_t load_value,
  output avalon_bus_pkg::byte_mask_t byteenable
);
  import avalon_bus_pkg::*;

  bus_word_t swapped;
  logic [7:0] picked;

  assign swapped = byte_swap(load_word);

  // offset 0 is the most significant byte
  always_comb begin
    case (byte_offset)
      2'd0: picked = swapped[31:24];
      2'd1: picked = swapped[23:16];
      2'd2: picked = swapped[15:8];
      default: picked = swapped[7:0];
    endcase
  end

  always_comb begin
    if (!load_byte) begin
      load_value = swapped;
    end else if (load_signed) begin
      load_value = {{24{picked[7]}}, picked};
    end else begin
      load_value = {24'h000000, picked};
    end
  end

  // byte stores copy the byte to every lane
  assign writedata = store_byte ? {lane_count{store_data[7:0]}} : byte_swap(store_data);
  assign byteenable = store_byte ? byte_mask_t'(1) << byte_offset : '1;

endmodule

// ==== datapath/mips_cpu_datapath.sv ====
`timescale 1ns/1ps

module mips_cpu_datapath #(
  parameter logic [31:0] reset_vector = 32'hbfc0_0000
) (
  input  logic clk,
  input  logic reset,
  input  logic waitrequest,
  cpu_ctrl_if.datapath ctrl,
  input  avalon_bus_pkg::bus_word_t readdata,
  output avalon_bus_pkg::bus_word_t address,
  output avalon_bus_pkg::bus_word_t writedata,
  output avalon_bus_pkg::byte_mask_t byteenable,
  output avalon_bus_pkg::bus_word_t register_v0
);
  import avalon_bus_pkg::*;
  import mips_isa_pkg::*;

  bus_word_t pc;
  bus_word_t ir;
  bus_word_t reg_a;
  bus_word_t reg_b;
  bus_word_t alu_out;
  bus_word_t mdr;
  bus_word_t alu_a;
  bus_word_t alu_b;
  bus_word_t alu_result;
  bus_word_t imm_ext;
  bus_word_t jump_target;
  bus_word_t pc_next;
  bus_word_t rf_data_1;
  bus_word_t rf_data_2;
  bus_word_t write_data;
  bus_word_t load_value;
  logic [4:0] write_reg;
  logic stall;
  logic branch_taken;

  // a bus transfer held off by the slave freezes A and B
  assign stall = waitrequest & (ctrl.mem_read | ctrl.mem_write);

  assign ctrl.opcode = opcode_t'(ir[31:26]);
  assign ctrl.funct = funct_t'(ir[5:0]);
  assign ctrl.pc_is_zero = (pc == '0);

  // andi, ori, xori and lui take a zero-extended immediate
  assign imm_ext = (ir[31:28] == 4'b0011) ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
  assign jump_target = {pc[31:28], ir[25:0], 2'b00};

  assign alu_a = ctrl.alu_src_a ? reg_a : pc;

  always_comb begin
    case (ctrl.alu_src_b)
      2'b00: alu_b = reg_b;
      2'b01: alu_b = 32'd4;
      2'b10: alu_b = imm_ext;
      default: alu_b = {imm_ext[29:0], 2'b00};
    endcase
  end

  always_comb begin
    case (ctrl.pc_source)
      2'b00: pc_next = alu_result;
      2'b01: pc_next = alu_out;
      2'b10: pc_next = jump_target;
      default: pc_next = reg_a;
    endcase
  end

  assign branch_taken = ctrl.pc_write_cond & (ctrl.zero != ctrl.branch_on_ne);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (ctrl.pc_write || branch_taken) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      ir <= byte_swap(readdata);
    end
    if (!stall) begin
      reg_a <= rf_data_1;
      reg_b <= rf_data_2;
    end
    if (ctrl.alu_out_en) begin
      alu_out <= alu_result;
    end
    if (ctrl.mem_read && !waitrequest) begin
      mdr <= readdata;
    end
  end

  // data accesses are word aligned, byteenable picks the lane
  assign address = ctrl.iord ? {alu_out[31:2], 2'b00} : pc;

  always_comb begin
    case (ctrl.reg_dst)
      2'b00: write_reg = ir[20:16];
      2'b01: write_reg = ir[15:11];
      default: write_reg = 5'd31;
    endcase
  end

  // link writes take the already advanced pc
  assign write_data = (ctrl.reg_dst == 2'b10) ? pc : (ctrl.mem_to_reg ? load_value : alu_out);

  mips_cpu_alu i_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .shamt  (ir[10:6]),
    .result (alu_result),
    .zero   (ctrl.zero)
  );

  mips_cpu_register_file i_register_file (
    .clk          (clk),
    .reset        (reset),
    .write_enable (ctrl.reg_write),
    .read_reg_1   (ir[25:21]),
    .read_reg_2   (ir[20:16]),
    .write_reg    (write_reg),
    .write_data   (write_data),
    .read_data_1  (rf_data_1),
    .read_data_2  (rf_data_2),
    .read_data_v0 (register_v0)
  );

  mips_cpu_mem_align i_mem_align (
    .byte_offset (alu_out[1:0]),
    .store_byte  (ctrl.store_byte),
    .load_byte   (ctrl.load_byte),
    .load_signed (ctrl.load_signed),
    .store_data  (reg_b),
    .load_word   (mdr),
    .writedata   (writedata),
    .load_value  (load_value),
    .byteenable  (byteenable)
  );

endmodule

// ==== control/mips_cpu_controller.sv ====
`timescale 1ns/1ps

module mips_cpu_controller (
  input  logic clk,
  input  logic reset,
  input  logic waitrequest,
  cpu_ctrl_if.controller ctrl,
  output logic active
);
  import mips_isa_pkg::*;

  cpu_state_t state;
  cpu_state_t state_next;
  logic is_load;
  logic is_store;
  alu_op_t funct_op;
  alu_op_t imm_op;

  assign is_load = (ctrl.opcode == op_lw) || (ctrl.opcode == op_lb) || (ctrl.opcode == op_lbu);
  assign is_store = (ctrl.opcode == op_sw) || (ctrl.opcode == op_sb);

  // register-register alu operation
  always_comb begin
    case (ctrl.funct)
      fn_subu: funct_op = alu_sub;
      fn_and:  funct_op = alu_and;
      fn_or:   funct_op = alu_or;
      fn_xor:  funct_op = alu_xor;
      fn_nor:  funct_op = alu_nor;
      fn_slt:  funct_op = alu_slt;
      fn_sltu: funct_op = alu_sltu;
      fn_sll:  funct_op = alu_sll;
      fn_srl:  funct_op = alu_srl;
      fn_sra:  funct_op = alu_sra;
      default: funct_op = alu_add;
    endcase
  end

  // immediate alu operation
  always_comb begin
    case (ctrl.opcode)
      op_slti:  imm_op = alu_slt;
      op_sltiu: imm_op = alu_sltu;
      op_andi:  imm_op = alu_and;
      op_ori:   imm_op = alu_or;
      op_xori:  imm_op = alu_xor;
      op_lui:   imm_op = alu_lui;
      default:  imm_op = alu_add;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      active <= 1'b1;
    end else begin
      state <= state_next;
      if (state_next == st_halt) begin
        active <= 1'b0;
      end
    end
  end

  always_comb begin
    state_next = state;
    ctrl.ir_write = 1'b0;
    ctrl.pc_write = 1'b0;
    ctrl.pc_write_cond = 1'b0;
    ctrl.branch_on_ne = 1'b0;
    ctrl.pc_source = 2'b00;
    ctrl.iord = 1'b0;
    ctrl.alu_src_a = 1'b0;
    ctrl.alu_src_b = 2'b00;
    ctrl.alu_op = alu_add;
    ctrl.reg_dst = 2'b00;
    ctrl.mem_to_reg = 1'b0;
    ctrl.reg_write = 1'b0;
    ctrl.alu_out_en = 1'b0;
    ctrl.mem_read = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.load_byte = 1'b0;
    ctrl.load_signed = 1'b0;
    ctrl.store_byte = 1'b0;

    case (state)
      st_fetch: begin
        if (ctrl.pc_is_zero) begin
          state_next = st_halt;
        end else if (!reset) begin
          // pc + 4 lands together with the instruction word
          ctrl.mem_read = 1'b1;
          ctrl.alu_src_b = 2'b01;
          ctrl.ir_write = !waitrequest;
          ctrl.pc_write = !waitrequest;
          if (!waitrequest) begin
            state_next = st_decode;
          end
        end
      end
      st_decode: begin
        // branch target, used only by beq and bne
        ctrl.alu_src_b = 2'b11;
        ctrl.alu_out_en = 1'b1;
        state_next = st_execute;
      end
      st_execute: begin
        ctrl.alu_src_a = 1'b1;
        state_next = st_fetch;
        case (ctrl.opcode)
          op_special: begin
            if (ctrl.funct == fn_jr) begin
              ctrl.pc_write = 1'b1;
              ctrl.pc_source = 2'b11;
            end else begin
              ctrl.alu_op = funct_op;
              ctrl.alu_out_en = 1'b1;
              state_next = st_writeback;
            end
          end
          op_beq, op_bne: begin
            ctrl.alu_op = alu_sub;
            ctrl.pc_write_cond = 1'b1;
            ctrl.branch_on_ne = (ctrl.opcode == op_bne);
            ctrl.pc_source = 2'b01;
          end
          op_j, op_jal: begin
            ctrl.pc_write = 1'b1;
            ctrl.pc_source = 2'b10;
            // link gets the pc of the next instruction
            ctrl.reg_write = (ctrl.opcode == op_jal);
            ctrl.reg_dst = 2'b10;
          end
          op_lw, op_lb, op_lbu, op_sw, op_sb: begin
            ctrl.alu_src_b = 2'b10;
            ctrl.alu_out_en = 1'b1;
            state_next = st_memory;
          end
          op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
            ctrl.alu_src_b = 2'b10;
            ctrl.alu_op = imm_op;
            ctrl.alu_out_en = 1'b1;
            state_next = st_writeback;
          end
          default: begin
            // unsupported opcode runs as a nop
            state_next = st_fetch;
          end
        endcase
      end
      st_memory: begin
        ctrl.iord = 1'b1;
        ctrl.mem_read = is_load;
        ctrl.mem_write = is_store;
        ctrl.store_byte = (ctrl.opcode == op_sb);
        if (!waitrequest) begin
          state_next = is_load ? st_writeback : st_fetch;
        end
      end
      st_writeback: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst = (ctrl.opcode == op_special) ? 2'b01 : 2'b00;
        ctrl.mem_to_reg = is_load;
        ctrl.load_byte = (ctrl.opcode == op_lb) || (ctrl.opcode == op_lbu);
        ctrl.load_signed = (ctrl.opcode == op_lb);
        state_next = st_fetch;
      end
      default: begin
        // halted until reset
        state_next = st_halt;
      end
    endcase
  end

endmodule

// ==== logic/mips_cpu_bus.sv ====
`timescale 1ns/1ps

module mips_cpu_bus #(
  parameter logic [31:0] reset_vector = 32'hbfc0_0000
) (
  input  logic clk,
  input  logic reset,
  input  logic waitrequest,
  input  avalon_bus_pkg::bus_word_t readdata,
  output avalon_bus_pkg::bus_word_t address,
  output avalon_bus_pkg::bus_word_t writedata,
  output logic read,
  output logic write,
  output avalon_bus_pkg::byte_mask_t byteenable,
  output logic active,
  output avalon_bus_pkg::bus_word_t register_v0
);

  cpu_ctrl_if ctrl_if ();

  mips_cpu_controller i_controller (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .ctrl        (ctrl_if.controller),
    .active      (active)
  );

  mips_cpu_datapath #(
    .reset_vector (reset_vector)
  ) i_datapath (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .ctrl        (ctrl_if.datapath),
    .readdata    (readdata),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .register_v0 (register_v0)
  );

  // bus strobes come straight from the FSM
  assign read = ctrl_if.mem_read;
  assign write = ctrl_if.mem_write;

endmodule

// ==== sim/tb_avalon_memory.sv ====
`timescale 1ns/1ps

module tb_avalon_memory (
  input  logic clk,
  input  logic load,
  input  avalon_bus_pkg::bus_word_t program_words [13],
  input  avalon_bus_pkg::bus_word_t data_word,
  input  avalon_bus_pkg::bus_word_t address,
  input  avalon_bus_pkg::bus_word_t writedata,
  input  logic read,
  input  logic write,
  input  avalon_bus_pkg::byte_mask_t byteenable,
  output avalon_bus_pkg::bus_word_t readdata,
  output logic waitrequest
);
  import avalon_bus_pkg::*;

  // words 16 and up sit at the reset vector, word 0 at 0x1000
  bus_word_t words [32];
  logic [15:0] lfsr = 16'd96;
  logic wait_bit = 1'b0;

  function automatic logic [4:0] word_index(input bus_word_t addr);
    return {addr[31], addr[5:2]};
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {1'b0, state[15:1]} ^ (state[0] ? 16'hb400 : 16'h0000);
  endfunction

  function automatic bus_word_t fill_word(input logic [4:0] index);
    bus_word_t base;
    base = index[4] ? 32'hbfc0_0000 : 32'h0000_1000;
    return ~(base + {26'd0, index[3:0], 2'b00});
  endfunction

  initial begin
    for (int i = 0; i < 32; i++) begin
      words[i] = fill_word(5'(i));
    end
  end

  always @(posedge clk) begin
    wait_bit <= lfsr[0];
    lfsr <= lfsr_step(lfsr);
    if (load) begin
      for (int k = 0; k < 13; k++) begin
        words[16 + k] <= program_words[k];
      end
      words[0] <= data_word;
    end else if (write && !wait_bit) begin
      for (int lane = 0; lane < lane_count; lane++) begin
        if (byteenable[lane]) begin
          words[word_index(address)][8*lane +: 8] <= writedata[8*lane +: 8];
        end
      end
    end
  end

  assign waitrequest = wait_bit;
  assign readdata = read ? words[word_index(address)] : '0;

endmodule

// ==== sim/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ps

module tb_mips_cpu_bus;
  import avalon_bus_pkg::*;

  localparam logic [31:0] reset_vector = 32'hbfc0_0000;
  localparam int record_words = 16;
  localparam int record_count = 3;
  localparam int program_length = 13;
  localparam int halt_timeout = 4000;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic load = 1'b0;
  logic waitrequest;
  logic read;
  logic write;
  logic active;
  bus_word_t readdata;
  bus_word_t address;
  bus_word_t writedata;
  bus_word_t register_v0;
  byte_mask_t byteenable;

  logic [31:0] golden [record_count*record_words];
  bus_word_t program_words [program_length];
  bus_word_t data_word;
  int error_count = 0;
  int check_count = 0;
  int reset_edges = 0;

  // bus values from the previous cycle
  logic prev_reset = 1'b1;
  logic prev_pending = 1'b0;
  logic prev_read = 1'b0;
  logic prev_write = 1'b0;
  bus_word_t prev_address = '0;
  bus_word_t prev_writedata = '0;
  byte_mask_t prev_byteenable = '0;

  always #2 clk = ~clk;

  mips_cpu_bus #(
    .reset_vector (reset_vector)
  ) i_dut (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .address     (address),
    .writedata   (writedata),
    .read        (read),
    .write       (write),
    .byteenable  (byteenable),
    .active      (active),
    .register_v0 (register_v0)
  );

  tb_avalon_memory i_memory (
    .clk           (clk),
    .load          (load),
    .program_words (program_words),
    .data_word     (data_word),
    .address       (address),
    .writedata     (writedata),
    .read          (read),
    .write         (write),
    .byteenable    (byteenable),
    .readdata      (readdata),
    .waitrequest   (waitrequest)
  );

  // big-endian word to bus lane order and back
  function automatic logic [31:0] reverse_bytes(input logic [31:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
    error_count++;
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      reset_edges <= reset_edges + 1;
    end else begin
      reset_edges <= 0;
    end
  end

  // reset state and back-pressure monitor
  always @(negedge clk) begin
    if (reset) begin
      if (reset_edges > 0) begin
        check_count++;
        if (write !== 1'b0) report_mismatch("write in reset", {31'd0, write}, 32'd0);
        if (read !== 1'b0) report_mismatch("read in reset", {31'd0, read}, 32'd0);
        if (active !== 1'b1) report_mismatch("active in reset", {31'd0, active}, 32'd1);
      end
    end else if (prev_reset) begin
      check_count++;
      if (write !== 1'b0) report_mismatch("write after reset", {31'd0, write}, 32'd0);
      if (active !== 1'b1) report_mismatch("active after reset", {31'd0, active}, 32'd1);
      if (read !== 1'b1) report_mismatch("read after reset", {31'd0, read}, 32'd1);
      if (address !== reset_vector) report_mismatch("first address", address, reset_vector);
    end
    if (!reset && prev_pending) begin
      check_count++;
      if (address !== prev_address) report_mismatch("held address", address, prev_address);
      if (read !== prev_read) report_mismatch("held read", {31'd0, read}, {31'd0, prev_read});
      if (write !== prev_write) begin
        report_mismatch("held write", {31'd0, write}, {31'd0, prev_write});
      end
      if (writedata !== prev_writedata) begin
        report_mismatch("held writedata", writedata, prev_writedata);
      end
      if (byteenable !== prev_byteenable) begin
        report_mismatch("held byteenable", {28'd0, byteenable}, {28'd0, prev_byteenable});
      end
    end
    prev_reset = reset;
    prev_pending = !reset && (read || write) && waitrequest;
    prev_read = read;
    prev_write = write;
    prev_address = address;
    prev_writedata = writedata;
    prev_byteenable = byteenable;
  end

  // load the record into memory inside an 8-cycle reset
  task automatic start_record(input int rec);
    @(posedge clk);
    reset <= 1'b1;
    load <= 1'b1;
    for (int k = 0; k < program_length; k++) begin
      program_words[k] <= reverse_bytes(golden[rec*record_words + k]);
    end
    data_word <= reverse_bytes(golden[rec*record_words + program_length]);
    @(posedge clk);
    load <= 1'b0;
    repeat (7) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_for_halt(output bit timed_out);
    int cycles;
    cycles = 0;
    timed_out = 1'b1;
    while (cycles < halt_timeout) begin
      @(negedge clk);
      if (!active) begin
        timed_out = 1'b0;
        break;
      end
      cycles++;
    end
  endtask

  task automatic check_results(input int rec);
    logic [31:0] final_word;
    final_word = reverse_bytes(i_memory.words[0]);
    check_count++;
    if (register_v0 !== golden[rec*record_words + 14]) begin
      report_mismatch("register_v0", register_v0, golden[rec*record_words + 14]);
    end
    check_count++;
    if (final_word !== golden[rec*record_words + 15]) begin
      report_mismatch("data word at 0x1000", final_word, golden[rec*record_words + 15]);
    end
  endtask

  initial begin
    bit timed_out;
    data_word = '0;
    for (int k = 0; k < program_length; k++) begin
      program_words[k] = '0;
    end
    timed_out = 1'b0;
    $readmemh("sim/mips_golden.mem", golden);
    for (int rec = 0; rec < record_count && !timed_out; rec++) begin
      start_record(rec);
      wait_for_halt(timed_out);
      if (timed_out) begin
        $display("record %0d did not halt within %0d cycles", rec, halt_timeout);
      end else begin
        check_results(rec);
      end
    end
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/mips_golden.mem ====
// per record: 13 program words (big-endian), initial word at 0x1000,
// expected register_v0, expected final word at 0x1000
24080005
2409fffd
01095021
01095823
000b5900
3c021234
004b1025
010a4026
01094024
0128482a
00481021
00491021
00000008
cafef00d
12340086
cafef00d
24081000
8d090000
240a00f0
a10a0001
810b0001
91020001
004b1021
8d0a0000
004a1021
ad090000
a10b0003
a1020000
00000008
11223344
11f03424
242233f0
24080005
24020000
00481021
2508ffff
1500fffd
0ff00009
24420064
0bf0000c
24020000
11000001
24020000
03e00008
00000008
0badf00d
00000073
0badf00d

// ==== mips_cpu_bus.f ====
common/mips_isa_pkg.sv
common/avalon_bus_pkg.sv
common/cpu_ctrl_if.sv
datapath/mips_cpu_alu.sv
datapath/mips_cpu_register_file.sv
datapath/mips_cpu_mem_align.sv
datapath/mips_cpu_datapath.sv
control/mips_cpu_controller.sv
logic/mips_cpu_bus.sv
sim/tb_avalon_memory.sv
sim/tb_mips_cpu_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mips_cpu_bus \
  -f mips_cpu_bus.f -o tb_mips_cpu_bus_sim \
  && ./obj_dir/tb_mips_cpu_bus_sim | tee /dev/stderr | grep -q "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
